// File: dv/tb_clk_gen.sv
// free running testbench clock, 8 ns period by default
// no enable, runs until the simulation ends
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD_NS = 4
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(HALF_PERIOD_NS) clk_o = ~clk_o; // toggles every half period

endmodule

// File: dv/tb_uart_tx.sv
// testbench for uart_tx, decodes tx_o at bit centres against the written bytes
// prescaler_i is only changed while the line is idle
`timescale 1ns/1ps
`include "uart_tx_macros.svh"

module tb_uart_tx;
    import uart_tx_pkg::*;

    localparam int DEPTH     = `UART_TX_DEPTH;
    localparam int N_FRAMES  = 5 + 5 + (DEPTH + 4) + 4;
    localparam int MAX_PRESC = 15;
    localparam int WDOG_NS   = N_FRAMES * 10 * (MAX_PRESC + 1) * 8 * 3 / 2; // 50% margin

    logic        clk;
    logic        arst_n_i;
    logic [15:0] prescaler_i;
    logic        clear_i;
    logic [7:0]  dat_i;
    logic        we_i;
    logic        stb_i;
    logic        ack_o;
    logic        full_o;
    logic        empty_o;
    fifo_size_t  size_o;
    logic        tx_o;

    logic [7:0] exp_q[$]; // bytes accepted, not yet seen on the line
    integer     seed = 32'h849;
    int         err_cnt = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         frame_cnt = 0; // start bits seen
    logic       full_seen = 1'b0;

    tb_clk_gen clk_gen_i (.clk_o(clk));

    uart_tx #(
        .DEPTH(DEPTH)
    ) uart_tx_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .prescaler_i(prescaler_i),
        .clear_i    (clear_i),
        .dat_i      (dat_i),
        .we_i       (we_i),
        .stb_i      (stb_i),
        .ack_o      (ack_o),
        .full_o     (full_o),
        .empty_o    (empty_o),
        .size_o     (size_o),
        .tx_o       (tx_o)
    );

    function automatic int errors_now();
        return err_cnt + uart_tx_i.uart_tx_assert_i.fail_cnt;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            err_cnt++;
            $display("error: %0t ns %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // holds the strobe and moves to the next byte once ack is seen
    task automatic write_bytes(input int n);
        for (int i = 0; i < n; i++) begin
            dat_i = 8'($random(seed));
            stb_i = 1'b1;
            we_i  = 1'b1;
            @(negedge clk);
            while (!ack_o) @(negedge clk);
            exp_q.push_back(dat_i);
        end
        stb_i = 1'b0;
        we_i  = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) @(negedge clk);
        while (!empty_o || !tx_o) @(negedge clk);
        repeat (prescaler_i + 2) @(negedge clk); // rest of the stop bit
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors_now() == errs_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end
    endtask

    always @(negedge clk) begin
        if (full_o) full_seen = 1'b1;
    end

    initial begin : decoder
        logic [7:0] got;
        logic [7:0] exp;
        int         bit_cycles;
        wait (arst_n_i === 1'b1);
        forever begin
            @(negedge tx_o);
            frame_cnt++;
            bit_cycles = prescaler_i + 1;
            repeat (bit_cycles / 2) @(negedge clk); // centre of the start bit
            check_value("tx_o start bit", tx_o, 1'b0);
            for (int i = 0; i < 8; i++) begin
                repeat (bit_cycles) @(negedge clk);
                got[i] = tx_o; // lsb first
            end
            repeat (bit_cycles) @(negedge clk);
            check_value("tx_o stop bit", tx_o, 1'b1);
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("error: %0t ns frame on tx_o with no byte written", $time);
            end else begin
                exp = exp_q.pop_front();
                assert (got == exp) else begin
                    err_cnt++;
                    $display("error: %0t ns tx_o decoded %02h expected %02h", $time, got, exp);
                end
            end
        end
    end

    initial begin : watchdog
        #(WDOG_NS * 1ns);
        $display("timeout: simulation did not finish within %0d ns", WDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        int errs;
        int frames_before;
        $timeformat(-9, 0, "", 0);
        arst_n_i    = 1'b0;
        prescaler_i = 16'd7;
        clear_i     = 1'b0;
        dat_i       = 8'h00;
        we_i        = 1'b0;
        stb_i       = 1'b0;
        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;

        errs = errors_now();
        repeat (5) begin
            @(negedge clk);
            check_value("tx_o", tx_o, 1'b1);
            check_value("ack_o", ack_o, 1'b0);
            check_value("empty_o", empty_o, 1'b1);
            check_value("full_o", full_o, 1'b0);
            check_value("size_o", size_o, '0);
        end
        end_test("reset state", errs);

        errs = errors_now();
        write_bytes(5);
        wait_idle();
        end_test("framing prescaler 7", errs);

        errs = errors_now();
        prescaler_i = 16'd3; // line idle and fifo empty here
        write_bytes(5);
        wait_idle();
        end_test("framing prescaler 3", errs);

        errs = errors_now();
        prescaler_i = 16'd15;
        full_seen   = 1'b0;
        write_bytes(DEPTH + 4);
        wait_idle();
        assert (full_seen) else begin
            err_cnt++;
            $display("full_o never rose while writing more bytes than the fifo holds");
        end
        end_test("back-pressure", errs);

        errs          = errors_now();
        frames_before = frame_cnt;
        write_bytes(4); // first byte goes straight to the serializer
        check_value("size_o", size_o, 16'd3); // three bytes left waiting
        clear_i = 1'b1;
        @(negedge clk);
        clear_i = 1'b0;
        check_value("size_o", size_o, '0);
        check_value("empty_o", empty_o, 1'b1);
        repeat (3) void'(exp_q.pop_back()); // flushed bytes never reach the line
        wait_idle();
        repeat (2 * 10 * (prescaler_i + 1)) @(negedge clk);
        check_value("frames on tx_o", 16'(frame_cnt), 16'(frames_before + 1));
        end_test("clear", errs);

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors_now() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: dv/uart_tx_assert.sv
// port and status checks for uart_tx, bound into every uart_tx instance
// serializer state is taken by hierarchical reference into serializer_i
`timescale 1ns/1ps
`include "uart_tx_macros.svh"

module uart_tx_assert #(
    parameter int DEPTH = `UART_TX_DEPTH
) (
    input logic                    clk,
    input logic                    arst_n_i,
    input logic                    clear_i,
    input logic                    we_i,
    input logic                    stb_i,
    input logic                    ack_i,
    input logic                    full_i,
    input logic                    empty_i,
    input uart_tx_pkg::fifo_size_t size_i,
    input logic                    tx_i,
    input uart_tx_pkg::tx_state_e  state_i
);
    import uart_tx_pkg::*;

    int fail_cnt;

    initial fail_cnt = 0;

    // ack follows exactly one accepted strobe
    ack_follows_accept: assert property (@(posedge clk) disable iff (!arst_n_i)
        ack_i == $past(stb_i && we_i && !ack_i && !full_i && !clear_i))
        else begin
            fail_cnt++;
            $error("ack_o does not match the accept condition of the previous cycle");
        end

    ack_single_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
        ack_i |=> !ack_i)
        else begin
            fail_cnt++;
            $error("ack_o high for two cycles in a row");
        end

    empty_matches_size: assert property (@(posedge clk) disable iff (!arst_n_i)
        empty_i == (size_i == '0))
        else begin
            fail_cnt++;
            $error("empty_o disagrees with size_o");
        end

    full_matches_size: assert property (@(posedge clk) disable iff (!arst_n_i)
        full_i == (size_i == fifo_size_t'(DEPTH)))
        else begin
            fail_cnt++;
            $error("full_o disagrees with size_o");
        end

    size_in_range: assert property (@(posedge clk) disable iff (!arst_n_i)
        size_i <= fifo_size_t'(DEPTH))
        else begin
            fail_cnt++;
            $error("size_o above fifo depth");
        end

    // line must be high outside start and data bits
    tx_high_when_quiet: assert property (@(posedge clk) disable iff (!arst_n_i)
        (state_i inside {ST_IDLE, ST_STOP}) |-> tx_i)
        else begin
            fail_cnt++;
            $error("tx_o low while the serializer is idle or sending the stop bit");
        end

endmodule

bind uart_tx uart_tx_assert #(
    .DEPTH(DEPTH)
) uart_tx_assert_i (
    .clk     (clk),
    .arst_n_i(arst_n_i),
    .clear_i (clear_i),
    .we_i    (we_i),
    .stb_i   (stb_i),
    .ack_i   (ack_o),
    .full_i  (full_o),
    .empty_i (empty_o),
    .size_i  (size_o),
    .tx_i    (tx_o),
    .state_i (serializer_i.state_q)
);

// File: rtl/uart_tx.sv
// buffered 8N1 uart transmitter with a strobe/ack write port
// DEPTH must be a power of two, 2 or more
`timescale 1ns/1ps
`include "uart_tx_macros.svh"

module uart_tx #(
    parameter int DEPTH = `UART_TX_DEPTH
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic [15:0]             prescaler_i,
    input  logic                    clear_i,
    input  logic [7:0]              dat_i,
    input  logic                    we_i,
    input  logic                    stb_i,
    output logic                    ack_o,
    output logic                    full_o,
    output logic                    empty_o,
    output uart_tx_pkg::fifo_size_t size_o,
    output logic                    tx_o
);

    logic [7:0] byte_data;  // fifo head
    logic       byte_valid;
    logic       byte_pop;

    uart_tx_fifo #(
        .DEPTH(DEPTH)
    ) fifo_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .clear_i     (clear_i),
        .dat_i       (dat_i),
        .we_i        (we_i),
        .stb_i       (stb_i),
        .ack_o       (ack_o),
        .byte_data_o (byte_data),
        .byte_valid_o(byte_valid),
        .byte_pop_i  (byte_pop),
        .full_o      (full_o),
        .empty_o     (empty_o),
        .size_o      (size_o)
    );

    // a frame in flight is not affected by clear_i
    uart_tx_serializer serializer_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .prescaler_i (prescaler_i),
        .byte_data_i (byte_data),
        .byte_valid_i(byte_valid),
        .byte_pop_o  (byte_pop),
        .tx_o        (tx_o)
    );

endmodule

// File: rtl/uart_tx_fifo.sv
// DEPTH must be a power of two, 2 or more
// accepts at most one byte every two cycles, strobes wait while full
`timescale 1ns/1ps
`include "uart_tx_macros.svh"

module uart_tx_fifo #(
    parameter int DEPTH = `UART_TX_DEPTH
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    clear_i,
    input  logic [7:0]              dat_i,
    input  logic                    we_i,
    input  logic                    stb_i,
    output logic                    ack_o,
    output logic [7:0]              byte_data_o,
    output logic                    byte_valid_o,
    input  logic                    byte_pop_i,
    output logic                    full_o,
    output logic                    empty_o,
    output uart_tx_pkg::fifo_size_t size_o
);
    import uart_tx_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam fifo_size_t DEPTH_SZ = fifo_size_t'(DEPTH);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    fifo_size_t    count_q;
    fifo_size_t    count_nxt;
    logic          full_q;
    logic          empty_q;
    logic          ack_q;
    logic          push;
    logic          pop;

    // ack must drop before the next byte is taken, so the master can
    // change dat_i after seeing ack
    assign push = stb_i && we_i && !ack_q && !full_q && !clear_i;
    assign pop  = byte_pop_i && !empty_q && !clear_i;

    always_comb begin
        if (clear_i) begin
            count_nxt = '0; // flush wins over everything
        end else begin
            count_nxt = count_q;
            case ({push, pop})
                2'b10:   count_nxt = count_q + 1'b1;
                2'b01:   count_nxt = count_q - 1'b1;
                default: count_nxt = count_q; // idle or push with pop
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            full_q   <= 1'b0;
            empty_q  <= 1'b1;
            ack_q    <= 1'b0;
        end else begin
            ack_q   <= push; // one cycle pulse after acceptance
            count_q <= count_nxt;
            full_q  <= (count_nxt == DEPTH_SZ);
            empty_q <= (count_nxt == '0);
            if (clear_i) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
            end else begin
                if (push) begin
                    wr_ptr_q <= wr_ptr_q + 1'b1; // wraps, depth is a power of two
                end
                if (pop) begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
        end
    end

    // byte storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= dat_i;
        end
    end

    assign ack_o        = ack_q;
    assign byte_data_o  = mem[rd_ptr_q]; // head byte
    assign byte_valid_o = !empty_q;
    assign full_o       = full_q;
    assign empty_o      = empty_q;
    assign size_o       = count_q;

endmodule

// File: rtl/uart_tx_macros.svh
// default sizing for the buffered uart transmitter
// UART_TX_DEPTH must stay a power of two, 2 or more
`ifndef UART_TX_MACROS_SVH
`define UART_TX_MACROS_SVH

// bytes held by the fifo unless overridden through DEPTH
`define UART_TX_DEPTH 8

// width of the fill level output
`define UART_TX_SIZE_W 16

`endif

// File: rtl/uart_tx_pkg.sv
// shared types for the uart transmitter
// fill level width follows UART_TX_SIZE_W
`include "uart_tx_macros.svh"

package uart_tx_pkg;

    // serializer frame states
    typedef enum logic [1:0] {
        ST_IDLE,  // line high, waiting for a byte
        ST_START, // start bit, line low
        ST_DATA,  // eight data bits, lsb first
        ST_STOP   // stop bit, line high
    } tx_state_e;

    // fifo fill level
    typedef logic [`UART_TX_SIZE_W-1:0] fifo_size_t;

endpackage

// File: rtl/uart_tx_serializer.sv
// 8N1 framing, each bit lasts prescaler_i + 1 cycles
// prescaler_i is latched at frame start and held for the whole frame
`timescale 1ns/1ps

module uart_tx_serializer (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic [15:0] prescaler_i,
    input  logic [7:0]  byte_data_i,
    input  logic        byte_valid_i,
    output logic        byte_pop_o,
    output logic        tx_o
);
    import uart_tx_pkg::*;

    tx_state_e   state_q;
    logic [15:0] presc_q;
    logic [15:0] cnt_q;
    logic [2:0]  bit_idx_q;
    logic [7:0]  shift_q;
    logic        tx_q;
    logic        pop_q;
    logic        bit_end;
    logic        pop_req;
    logic        load;

    assign bit_end = (cnt_q == '0);

    // request the head while idle, or already in the last stop cycle so
    // the next start bit follows after a single idle cycle
    assign pop_req = byte_valid_i && !pop_q &&
                     ((state_q == ST_IDLE) || ((state_q == ST_STOP) && bit_end));

    // byte may vanish under a flush, so valid is checked again
    assign load = (state_q == ST_IDLE) && pop_q && byte_valid_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            tx_q      <= 1'b1; // line idles high
            pop_q     <= 1'b0;
        end else begin
            pop_q <= pop_req;
            case (state_q)
                ST_IDLE: begin
                    if (load) begin
                        state_q <= ST_START;
                        cnt_q   <= prescaler_i;
                        tx_q    <= 1'b0; // start bit
                    end
                end
                ST_START: begin
                    if (bit_end) begin
                        state_q   <= ST_DATA;
                        cnt_q     <= presc_q;
                        bit_idx_q <= '0;
                        tx_q      <= shift_q[0]; // bit 0
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                ST_DATA: begin
                    if (bit_end) begin
                        cnt_q <= presc_q;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= ST_STOP;
                            tx_q    <= 1'b1; // stop bit
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            tx_q      <= shift_q[0];
                        end
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                ST_STOP: begin
                    if (bit_end) begin
                        state_q <= ST_IDLE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // frame payload, shifted right as each bit goes out
    always_ff @(posedge clk) begin
        if (load) begin
            presc_q <= prescaler_i;
            shift_q <= byte_data_i;
        end else if (bit_end && ((state_q == ST_START) || (state_q == ST_DATA))) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    assign byte_pop_o = pop_q; // head leaves the fifo as ST_START is entered
    assign tx_o       = tx_q;

endmodule

// File: tb.f
+incdir+rtl
rtl/uart_tx_pkg.sv
rtl/uart_tx_fifo.sv
rtl/uart_tx_serializer.sv
rtl/uart_tx.sv
dv/tb_clk_gen.sv
dv/uart_tx_assert.sv
dv/tb_uart_tx.sv
